//--- hdl/dsp_pkg.sv
// Sample reducer shared types

package dsp_pkg;

    // ------------------------------
    // Gain word
    // ------------------------------

    localparam int GAIN_W = 16;  // Signed gain width.

    // ------------------------------
    // Rounding modes
    // ------------------------------

    // Code 3 is not a named mode; the rounding stage treats it as truncation.
    typedef enum logic [1:0] {
        RND_TRUNC   = 2'd0,  // Toward negative infinity.
        RND_TO_ZERO = 2'd1,  // Toward zero.
        RND_NEAREST = 2'd2   // Nearest, half rounds up.
    } round_mode_e;

    // ------------------------------
    // Per-beat control
    // ------------------------------

    // Sampled with every input beat and carried down the pipeline with it,
    // so a change takes effect exactly on the beat it arrives with.
    typedef struct packed {
        logic signed [GAIN_W-1:0] gain;  // Applied in the gain stage.
        round_mode_e              mode;  // Applied in the rounding stage.
    } beat_ctrl_t;

endpackage

//--- hdl/iq_gain.sv
// Per-channel gain stage

`timescale 1ns/10ps

module iq_gain
    import dsp_pkg::*;
#(
    parameter int CH_NUM  = 2,
    parameter int BITS_IN = 16
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic [CH_NUM-1:0][BITS_IN-1:0] tdata_i,  // Signed samples.
    input  logic                           tvalid_i,
    input  beat_ctrl_t                     ctrl_i,   // Gain and mode of this beat.

    output logic [CH_NUM-1:0][BITS_IN+GAIN_W-1:0] tdata_o,  // Full products.
    output logic                                  tvalid_o,
    output round_mode_e                           mode_o    // Mode for next stage.
);

    localparam int PROD_W = BITS_IN + GAIN_W;  // Full signed product width.

    logic [CH_NUM-1:0][PROD_W-1:0] prod;

    // ------------------------------
    // Multiply
    // ------------------------------

    for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
        logic signed [BITS_IN-1:0] sample;
        logic signed [PROD_W-1:0]  mult;

        assign sample  = $signed(tdata_i[i]);
        assign mult    = sample * $signed(ctrl_i.gain);  // Never overflows PROD_W.
        assign prod[i] = mult;
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
        end
        tdata_o <= prod;
        mode_o  <= ctrl_i.mode;  // The gain stops here.
    end

endmodule

//--- hdl/iq_round.sv
// Per-channel rounding stage

`timescale 1ns/10ps

module iq_round
    import dsp_pkg::*;
#(
    parameter int CH_NUM   = 2,
    parameter int BITS_IN  = 16,
    parameter int BITS_RND = 18
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic [CH_NUM-1:0][BITS_IN+GAIN_W-1:0] tdata_i,  // Full products.
    input  logic                                  tvalid_i,
    input  round_mode_e                           mode_i,   // Mode of this beat.

    output logic [CH_NUM-1:0][BITS_RND-1:0] tdata_o,  // Rounded samples.
    output logic                            tvalid_o
);

    localparam int PROD_W = BITS_IN + GAIN_W;  // Input word width.
    localparam int DROP_W = PROD_W - BITS_RND;  // Bits discarded.

    logic [CH_NUM-1:0][BITS_RND-1:0] rnd;

    // ------------------------------
    // Correction per channel
    // ------------------------------

    for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
        logic [PROD_W-1:0]   in;
        logic [BITS_RND-1:0] kept;
        logic                neg;
        logic                corr_rtz;
        logic                corr_nearest;
        logic                at_max;
        logic                corr;

        assign in   = tdata_i[i];
        assign kept = in[PROD_W-1 -: BITS_RND];  // Top bits survive.
        assign neg  = in[PROD_W-1];

        assign corr_rtz     = neg & (|in[DROP_W-1:0]);  // Negative with a fraction.
        assign corr_nearest = in[DROP_W-1];  // Half bit.

        // Largest positive kept value; adding one here would wrap negative.
        assign at_max = ~neg & (&in[PROD_W-2:DROP_W]);

        always_comb begin
            case (mode_i)
                RND_TO_ZERO: corr = corr_rtz;
                RND_NEAREST: corr = corr_nearest & ~at_max;
                default:     corr = 1'b0;  // Truncation, and code 3.
            endcase
        end

        assign rnd[i] = kept + {{(BITS_RND - 1){1'b0}}, corr};
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
        end
        tdata_o <= rnd;
    end

    // The mode comes from the control the source presented with the beat.
    a_mode_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        tvalid_i |-> mode_i inside {RND_TRUNC, RND_TO_ZERO, RND_NEAREST});

endmodule

//--- hdl/iq_clip.sv
// Per-channel saturating clipper

`timescale 1ns/10ps

module iq_clip #(
    parameter int CH_NUM   = 2,
    parameter int BITS_RND = 18,
    parameter int BITS_OUT = 16
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic [CH_NUM-1:0][BITS_RND-1:0] tdata_i,  // Rounded samples.
    input  logic                            tvalid_i,

    output logic [CH_NUM-1:0][BITS_OUT-1:0] tdata_o,  // Output samples.
    output logic                            tvalid_o,
    output logic [CH_NUM-1:0]               clip_o    // One flag per channel.
);

    localparam logic [BITS_OUT-1:0] MAX_POS = {1'b0, {(BITS_OUT - 1){1'b1}}};
    localparam logic [BITS_OUT-1:0] MAX_NEG = {1'b1, {(BITS_OUT - 1){1'b0}}};

    logic [CH_NUM-1:0][BITS_OUT-1:0] sat;
    logic [CH_NUM-1:0]               ovf;

    // ------------------------------
    // Saturation per channel
    // ------------------------------

    for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
        logic [BITS_RND-BITS_OUT:0] top;  // Discarded bits plus output sign.

        assign top    = tdata_i[i][BITS_RND-1:BITS_OUT-1];
        assign ovf[i] = ~((&top) | ~(|top));  // Not a pure sign extension.
        assign sat[i] = ~ovf[i] ? tdata_i[i][BITS_OUT-1:0] :
                        tdata_i[i][BITS_RND-1] ? MAX_NEG : MAX_POS;

        // A passed or saturated word never wraps to the opposite sign.
        a_sign_kept: assert property (@(posedge clk_i) disable iff (rst_i)
            tvalid_i |=> tdata_o[i][BITS_OUT-1] == $past(tdata_i[i][BITS_RND-1]));
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
            clip_o   <= '0;
        end else begin
            tvalid_o <= tvalid_i;
            clip_o   <= tvalid_i ? ovf : '0;  // Idle data raises no flag.
        end
        tdata_o <= sat;
    end

endmodule

//--- hdl/iq_reduce_top.sv
// Sample width reducer top

`timescale 1ns/10ps

module iq_reduce_top
    import dsp_pkg::*;
#(
    parameter int CH_NUM   = 2,
    parameter int BITS_IN  = 16,
    parameter int BITS_RND = 18,
    parameter int BITS_OUT = 16
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic [CH_NUM-1:0][BITS_IN-1:0]  tdata_i,   // Input samples.
    input  logic                            tvalid_i,
    input  beat_ctrl_t                      ctrl_i,    // Per-beat gain and mode.

    output logic [CH_NUM-1:0][BITS_OUT-1:0] tdata_o,   // Three cycles later.
    output logic                            tvalid_o,
    output logic [CH_NUM-1:0]               clip_o
);

    localparam int PROD_W = BITS_IN + GAIN_W;  // Gain stage output width.

    // ------------------------------
    // Stage links
    // ------------------------------

    logic [CH_NUM-1:0][PROD_W-1:0]   gain_data;
    logic                            gain_valid;
    round_mode_e                     gain_mode;  // Mode tagged to gain_data.
    logic [CH_NUM-1:0][BITS_RND-1:0] rnd_data;
    logic                            rnd_valid;

    iq_gain #(
        .CH_NUM  (CH_NUM),
        .BITS_IN (BITS_IN)
    ) u_gain (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tdata_i  (tdata_i),
        .tvalid_i (tvalid_i),
        .ctrl_i   (ctrl_i),
        .tdata_o  (gain_data),
        .tvalid_o (gain_valid),
        .mode_o   (gain_mode)
    );

    iq_round #(
        .CH_NUM   (CH_NUM),
        .BITS_IN  (BITS_IN),
        .BITS_RND (BITS_RND)
    ) u_round (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tdata_i  (gain_data),
        .tvalid_i (gain_valid),
        .mode_i   (gain_mode),
        .tdata_o  (rnd_data),
        .tvalid_o (rnd_valid)
    );

    iq_clip #(
        .CH_NUM   (CH_NUM),
        .BITS_RND (BITS_RND),
        .BITS_OUT (BITS_OUT)
    ) u_clip (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tdata_i  (rnd_data),
        .tvalid_i (rnd_valid),
        .tdata_o  (tdata_o),
        .tvalid_o (tvalid_o),
        .clip_o   (clip_o)
    );

endmodule

//--- test/tb_clock.sv
// Testbench clock source

`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0  // Full clock period.
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        clk_o = ~clk_o;  // Toggle every half period.
    end

endmodule

//--- test/tb_iq_reduce.sv
// IQ sample reducer testbench

`timescale 1ns/10ps

module tb_iq_reduce
    import dsp_pkg::*;
();

    localparam int CH_NUM   = 2;  // The vector file holds two channels.
    localparam int BITS_IN  = 16;
    localparam int BITS_RND = 18;
    localparam int BITS_OUT = 16;

    localparam int RESET_CYCLES  = 10;
    localparam int DRAIN_TIMEOUT = 50;  // Cycles allowed for the last outputs.
    localparam int QUIET_CYCLES  = 8;   // Idle cycles watched after draining.

    logic                            clk;
    logic                            rst;
    logic [CH_NUM-1:0][BITS_IN-1:0]  in_data;
    logic                            in_valid;
    beat_ctrl_t                      in_ctrl;
    logic [CH_NUM-1:0][BITS_OUT-1:0] out_data;
    logic                            out_valid;
    logic [CH_NUM-1:0]               out_clip;

    // Expected results, one entry per driven beat.
    string                           exp_name_q[$];
    logic [CH_NUM-1:0][BITS_OUT-1:0] exp_data_q[$];
    logic [CH_NUM-1:0]               exp_clip_q[$];

    int sent_count   = 0;
    int recv_count   = 0;
    int mismatches   = 0;
    int other_errors = 0;

    tb_clock #(.PERIOD_NS(4.0)) u_clock (.clk_o(clk));

    iq_reduce_top #(
        .CH_NUM   (CH_NUM),
        .BITS_IN  (BITS_IN),
        .BITS_RND (BITS_RND),
        .BITS_OUT (BITS_OUT)
    ) DUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .tdata_i  (in_data),
        .tvalid_i (in_valid),
        .ctrl_i   (in_ctrl),
        .tdata_o  (out_data),
        .tvalid_o (out_valid),
        .clip_o   (out_clip)
    );

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic send_beat(input string name, input int idle, input logic [1:0] mode,
                             input logic [GAIN_W-1:0] gain,
                             input logic [CH_NUM-1:0][BITS_IN-1:0] data,
                             input logic [CH_NUM-1:0][BITS_OUT-1:0] exp_data,
                             input logic [CH_NUM-1:0] exp_clip);
        for (int i = 0; i < idle; i++) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        in_data      = data;
        in_ctrl.gain = gain;
        in_ctrl.mode = round_mode_e'(mode);  // Travels with this beat only.
        in_valid     = 1'b1;
        exp_name_q.push_back(name);
        exp_data_q.push_back(exp_data);
        exp_clip_q.push_back(exp_clip);
        sent_count++;
    endtask

    initial begin
        int                  fd;
        int                  code;
        int                  fields;
        int                  idle;
        int                  waited;
        string               line;
        logic [8*24-1:0]     name_raw;
        logic [1:0]          mode;
        logic [GAIN_W-1:0]   gain;
        logic [BITS_IN-1:0]  in0;
        logic [BITS_IN-1:0]  in1;
        logic [BITS_OUT-1:0] exp0;
        logic [BITS_OUT-1:0] exp1;
        logic [CH_NUM-1:0]   clip;

        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        in_ctrl  = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
        end
        rst = 1'b0;

        fd = $fopen("test/iq_reduce_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: the vector file could not be opened");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %d %d %h %h %h %h %h %h", name_raw, idle,
                                     mode, gain, in0, in1, exp0, exp1, clip);
                    if (fields != 9) begin
                        $display("Error: a vector line could not be parsed: %0s", line);
                        other_errors++;
                    end else begin
                        send_beat($sformatf("%0s", name_raw), idle, mode, gain,
                                  {in1, in0}, {exp1, exp0}, clip);
                    end
                end
            end
            $fclose(fd);
        end
        @(negedge clk);
        in_valid = 1'b0;

        // Wait for every pending beat to come out.
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Error: timed out waiting for %0d output beats", exp_data_q.size());
            other_errors++;
        end

        // Stray outputs in this window are caught by the monitor.
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
        end
        if (recv_count != sent_count) begin
            $display("Error: %0d beats driven but %0d beats received", sent_count, recv_count);
            other_errors++;
        end

        $display("Summary: %0d beats sent, %0d received, %0d mismatches, %0d other errors",
                 sent_count, recv_count, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // ------------------------------
    // Output monitor
    // ------------------------------

    always @(negedge clk) begin
        string                           name;
        logic [CH_NUM-1:0][BITS_OUT-1:0] exp_data;
        logic [CH_NUM-1:0]               exp_clip;

        if (out_valid !== 1'b0 && sent_count == 0) begin
            $display("Error: output valid is not low before any beat was driven");
            other_errors++;
        end else if (out_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("Error: output beat arrived with no beat pending");
                other_errors++;
            end else begin
                name     = exp_name_q.pop_front();
                exp_data = exp_data_q.pop_front();
                exp_clip = exp_clip_q.pop_front();
                recv_count++;
                for (int ch = 0; ch < CH_NUM; ch++) begin
                    if (out_data[ch] !== exp_data[ch]) begin
                        $display("MISMATCH %0s ch%0d data: expected %h, actual %h",
                                 name, ch, exp_data[ch], out_data[ch]);
                        mismatches++;
                    end
                end
                if (out_clip !== exp_clip) begin
                    $display("MISMATCH %0s clip: expected %b, actual %b",
                             name, exp_clip, out_clip);
                    mismatches++;
                end
            end
        end else if (out_clip != '0) begin
            $display("Error: clip flag raised while output valid is low");
            other_errors++;
        end
    end

endmodule

//--- test/iq_reduce_vectors.txt
# name idle mode gain in0 in1 exp0 exp1 clip
# idle and mode are decimal; mode 0 trunc, 1 toward zero, 2 nearest; the rest hex
# Truncation with unity gain rounds toward negative infinity
trunc_neg     2 0 0001 ffff c001 ffff ffff 0
trunc_mix     1 0 0001 bfff 4001 fffe 0001 0
# Round toward zero moves negative values up by one
rtz_neg       1 1 0001 ffff c001 0000 0000 0
rtz_mix       1 1 0001 bfff 4001 ffff 0001 0
rtz_exact     1 1 0001 c000 8000 ffff fffe 0
# Round to nearest
near_half     1 2 2000 0003 fffd 0002 ffff 0
near_low      1 2 2000 0001 ffff 0001 0000 0
near_quarter  1 2 1000 0005 0007 0001 0002 0
near_top      1 2 5555 6000 2000 7fff 2aab 1
trunc_top     1 0 5555 6000 2000 7fff 2aaa 0
near_big      1 2 6000 7fff 0001 7fff 0002 1
# Clipping to the output width
clip_pos      1 0 7fff 7fff 0100 7fff 01ff 1
clip_neg      1 0 7fff 0100 8000 01ff 8000 2
clip_both     1 1 8000 8000 7fff 7fff 8000 3
clip_edge     1 0 4000 7fff 8000 7fff 8000 0
# Back-to-back beats with alternating control
mix_a         2 0 2000 0003 fffd 0001 fffe 0
mix_b         0 2 1000 0003 fffd 0001 ffff 0
mix_c         0 1 2000 0003 fffd 0001 ffff 0
mix_d         0 0 7fff 7fff fffd 7fff fffa 1
mix_e         0 1 ffff 0003 fffd 0000 0000 0
mix_f         0 2 c000 0003 8000 fffd 7fff 2
mix_g         0 0 4000 1234 edcc 1234 edcc 0

//--- all.f
hdl/dsp_pkg.sv
hdl/iq_gain.sv
hdl/iq_round.sv
hdl/iq_clip.sv
hdl/iq_reduce_top.sv
test/tb_clock.sv
test/tb_iq_reduce.sv

//--- run.sh
#!/bin/sh
# Build and run the IQ reducer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_iq_reduce -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log
